// ==== emmc_serdes_pkg.sv ====
package emmc_serdes_pkg;

   // One lane word per txclk_div cycle stands in for the 8:1 DDR stream
   localparam int LANE_W = 8;

   typedef logic [LANE_W-1:0] lane_word_t;

   // Clock lane training word, all eight rotations are distinct
   localparam lane_word_t TRAIN_PATTERN = 8'hC3;

   // Frame marker position in a data lane word
   localparam int MARK_BIT = LANE_W - 1;

   // Transmit side, lane word bits 6..0 in the same order
   typedef struct packed {
      logic [3:0] dat;     // Lane bits 6..3
      logic       dat_oe;  // Lane bit 2
      logic       cmd_oe;  // Lane bit 1
      logic       cmd;     // Lane bit 0
   } tx_frame_t;

   // Receive side, output enables are not returned
   typedef struct packed {
      logic [3:0] dat;     // From lane bits 6..3
      logic       cmd;     // From lane bit 0
   } rx_frame_t;

   // Bit-slip window offset, 0..7
   typedef logic [2:0] slip_t;

   // Alignment FSM
   typedef enum logic [1:0] {
      HUNT,    // Compare clock lane against pattern
      SLIP,    // One-cycle bitslip pulse
      SETTLE,  // Wait for the new window to come through
      LOCKED   // Pattern seen, link usable
   } align_state_t;

endpackage

// ==== emmc_tx_framer.sv ====
module emmc_tx_framer
   import emmc_serdes_pkg::*;
(
   input  logic       txclk_div,
   input  logic       rst,
   input  tx_frame_t  tx_frame_i,
   input  logic       tx_valid_i,
   input  logic       locked_i,
   output logic       tx_ready_o,
   output lane_word_t tx_data_word_o,
   output lane_word_t tx_clk_word_o
);

   logic       tx_accept;   // Frame taken this cycle
   lane_word_t data_word;   // Packed word or idle

   // No frames leave before the receive side is aligned
   assign tx_ready_o = locked_i;
   assign tx_accept  = tx_valid_i & tx_ready_o;

   // Marker in bit 7 tells a frame from an idle word
   always_comb begin
      if (tx_accept) begin
         data_word = {1'b1, tx_frame_i};
      end else begin
         data_word = '0;  // Idle
      end
   end

   always_ff @(posedge txclk_div) begin
      if (!rst) begin
         tx_data_word_o <= '0;
         tx_clk_word_o  <= '0;
      end else begin
         tx_data_word_o <= data_word;      // One word per cycle, no hold
         tx_clk_word_o  <= TRAIN_PATTERN;  // Clock lane always trains
      end
   end

endmodule

// ==== emmc_lane_deser.sv ====
module emmc_lane_deser
   import emmc_serdes_pkg::*;
(
   input  logic       txclk_div,
   input  logic       rst,
   input  lane_word_t lane_word_i,
   input  logic       bitslip_i,
   output lane_word_t aligned_o
);

   localparam int PAIR_W = 2 * LANE_W;

   lane_word_t        prev_q;   // Raw word from last cycle
   slip_t             offset_q; // Window start within the pair
   logic [PAIR_W-1:0] pair;     // 16 consecutive bits, MSB first
   logic [PAIR_W-1:0] shifted;
   lane_word_t        window;

   // Previous word is sent first on the wire
   assign pair = {prev_q, lane_word_i};

   // Barrel window, offset k skips the first k bits
   assign shifted = pair << offset_q;
   assign window  = shifted[PAIR_W-1 -: LANE_W];

   // Raw history keeps loading during reset too
   always_ff @(posedge txclk_div) begin
      prev_q <= lane_word_i;
   end

   always_ff @(posedge txclk_div) begin
      if (!rst) begin
         offset_q  <= '0;
         aligned_o <= '0;
      end else begin
         aligned_o <= window;  // Uses offset before any slip this edge
         if (bitslip_i) begin
            offset_q <= offset_q + 3'd1;  // Wraps 7 -> 0
         end
      end
   end

endmodule

// ==== emmc_bitslip_ctrl.sv ====
module emmc_bitslip_ctrl
   import emmc_serdes_pkg::*;
#(
   parameter int SETTLE_CYCLES = 2
) (
   input  logic       txclk_div,
   input  logic       rst,
   input  lane_word_t clk_word_i,
   output logic       bitslip_o,
   output logic       locked_o
);

   localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

   align_state_t     state_q;
   align_state_t     state_d;
   logic [CNT_W-1:0] settle_q;  // Cycles spent in SETTLE
   logic             match;     // Clock window shows the pattern
   logic             settle_done;

   assign match       = (clk_word_i == TRAIN_PATTERN);
   assign settle_done = (settle_q == CNT_W'(SETTLE_CYCLES - 1));

   // Moore outputs, low out of reset
   assign bitslip_o = (state_q == SLIP);
   assign locked_o  = (state_q == LOCKED);

   always_comb begin
      state_d = state_q;
      case (state_q)
         HUNT: begin
            if (match) begin
               state_d = LOCKED;
            end else begin
               state_d = SLIP;
            end
         end
         SLIP:   state_d = SETTLE;  // Single pulse
         SETTLE: begin
            if (settle_done) begin
               state_d = HUNT;  // New offset now visible
            end
         end
         LOCKED: begin
            if (!match) begin
               state_d = HUNT;  // Drop lock on any bad clock word
            end
         end
         default: state_d = HUNT;
      endcase
   end

   always_ff @(posedge txclk_div) begin
      if (!rst) begin
         state_q  <= HUNT;
         settle_q <= '0;
      end else begin
         state_q <= state_d;
         if (state_q == SETTLE) begin
            settle_q <= settle_q + CNT_W'(1);
         end else begin
            settle_q <= '0;  // Restart count for next slip
         end
      end
   end

endmodule

// ==== emmc_rx_unpack.sv ====
module emmc_rx_unpack
   import emmc_serdes_pkg::*;
(
   input  logic       txclk_div,
   input  logic       rst,
   input  lane_word_t data_word_i,
   input  logic       locked_i,
   output rx_frame_t  rx_frame_o,
   output logic       rx_valid_o,
   input  logic       rx_ready_i,
   output logic       rx_overrun_o
);

   logic marked;    // Frame word while the link is aligned
   logic can_load;  // Hold register free this cycle
   logic load;

   assign marked   = locked_i & data_word_i[MARK_BIT];
   assign can_load = ~rx_valid_o | rx_ready_i;
   assign load     = marked & can_load;

   // Output enable bits 2..1 are not returned
   always_ff @(posedge txclk_div) begin
      if (load) begin
         rx_frame_o.dat <= data_word_i[6:3];
         rx_frame_o.cmd <= data_word_i[0];
      end
   end

   always_ff @(posedge txclk_div) begin
      if (!rst) begin
         rx_valid_o   <= 1'b0;
         rx_overrun_o <= 1'b0;
      end else begin
         if (load) begin
            rx_valid_o <= 1'b1;
         end else if (rx_ready_i) begin
            rx_valid_o <= 1'b0;  // Consumed, nothing new
         end
         // Sticky, only reset clears it
         if (marked && !can_load) begin
            rx_overrun_o <= 1'b1;
         end
      end
   end

endmodule

// ==== emmc_serdes_top.sv ====
module emmc_serdes_top
   import emmc_serdes_pkg::*;
#(
   parameter int SETTLE_CYCLES = 2
) (
   input  logic       txclk_div,
   input  logic       rst,
   // Transmit handshake
   input  tx_frame_t  tx_frame_i,
   input  logic       tx_valid_i,
   output logic       tx_ready_o,
   // Transmit lanes
   output lane_word_t tx_data_word_o,
   output lane_word_t tx_clk_word_o,
   // Raw receive lanes
   input  lane_word_t rx_clk_word_i,
   input  lane_word_t rx_data_word_i,
   // Receive handshake
   output rx_frame_t  rx_frame_o,
   output logic       rx_valid_o,
   input  logic       rx_ready_i,
   // Status
   output logic       locked_o,
   output logic       rx_overrun_o
);

   logic       bitslip;     // Shared by both lanes
   logic       locked;
   lane_word_t clk_aligned;
   lane_word_t data_aligned;

   assign locked_o = locked;

   emmc_tx_framer u_tx_framer (
      .txclk_div      (txclk_div),
      .rst            (rst),
      .tx_frame_i     (tx_frame_i),
      .tx_valid_i     (tx_valid_i),
      .locked_i       (locked),
      .tx_ready_o     (tx_ready_o),
      .tx_data_word_o (tx_data_word_o),
      .tx_clk_word_o  (tx_clk_word_o)
   );

   // Same slip on both lanes keeps data aligned with clock
   emmc_lane_deser u_clk_lane (
      .txclk_div   (txclk_div),
      .rst         (rst),
      .lane_word_i (rx_clk_word_i),
      .bitslip_i   (bitslip),
      .aligned_o   (clk_aligned)
   );

   emmc_lane_deser u_data_lane (
      .txclk_div   (txclk_div),
      .rst         (rst),
      .lane_word_i (rx_data_word_i),
      .bitslip_i   (bitslip),
      .aligned_o   (data_aligned)
   );

   emmc_bitslip_ctrl #(
      .SETTLE_CYCLES (SETTLE_CYCLES)
   ) u_bitslip_ctrl (
      .txclk_div  (txclk_div),
      .rst        (rst),
      .clk_word_i (clk_aligned),
      .bitslip_o  (bitslip),
      .locked_o   (locked)
   );

   emmc_rx_unpack u_rx_unpack (
      .txclk_div    (txclk_div),
      .rst          (rst),
      .data_word_i  (data_aligned),
      .locked_i     (locked),
      .rx_frame_o   (rx_frame_o),
      .rx_valid_o   (rx_valid_o),
      .rx_ready_i   (rx_ready_i),
      .rx_overrun_o (rx_overrun_o)
   );

endmodule

// ==== emmc_serdes_properties.sv ====
module emmc_serdes_properties
   import emmc_serdes_pkg::*;
#(
   parameter int SETTLE_CYCLES = 2
) (
   input logic      txclk_div,
   input logic      rst,
   input logic      bitslip,
   input logic      tx_ready_o,
   input logic      locked_o,
   input rx_frame_t rx_frame_o,
   input logic      rx_valid_o,
   input logic      rx_ready_i,
   input logic      rx_overrun_o
);

   // Slip is a single pulse, SETTLE follows it
   a_slip_pulse: assert property (@(posedge txclk_div) disable iff (!rst)
      bitslip |=> !bitslip) else $error("bitslip high two cycles");

   // Full settle wait, then back in HUNT with no new slip yet
   a_settle_wait: assert property (@(posedge txclk_div) disable iff (!rst)
      $past(bitslip, SETTLE_CYCLES + 1) |-> !bitslip && !locked_o)
      else $error("settle wait after bitslip too short");

   a_ready_lock: assert property (@(posedge txclk_div) disable iff (!rst)
      tx_ready_o == locked_o) else $error("tx_ready_o differs from locked_o");

   // Held frame must not change under back-pressure
   a_hold_stable: assert property (@(posedge txclk_div) disable iff (!rst)
      rx_valid_o && !rx_ready_i |=> $stable(rx_frame_o) && rx_valid_o)
      else $error("rx_frame_o changed while held");

   a_overrun_sticky: assert property (@(posedge txclk_div)
      rst && $past(rst) && $past(rx_overrun_o) |-> rx_overrun_o)
      else $error("rx_overrun_o fell out of reset");

endmodule

bind emmc_serdes_top emmc_serdes_properties #(.SETTLE_CYCLES(SETTLE_CYCLES)) u_props (.*);

// ==== tb_emmc_serdes.sv ====
module tb_emmc_serdes
   import emmc_serdes_pkg::*;
();

   localparam int SETTLE_CYCLES = 2;
   localparam int N_LOCKS       = 3;   // Initial lock plus two relocks
   localparam int FRAME_CYC     = 80;  // Frame cycles per lock
   // Lock bound plus a few cycles of pipeline fill after reset or a phase change
   localparam int LOCK_BOUND    = 8 * (SETTLE_CYCLES + 2) + 4;
   localparam int TIMEOUT       = N_LOCKS * LOCK_BOUND + N_LOCKS * FRAME_CYC * 4 + 200;

   logic       txclk_div = 1'b0;
   logic       rst;
   tx_frame_t  tx_frame_i;
   logic       tx_valid_i;
   logic       tx_ready_o;
   lane_word_t tx_data_word_o;
   lane_word_t tx_clk_word_o;
   lane_word_t rx_clk_word_i;
   lane_word_t rx_data_word_i;
   rx_frame_t  rx_frame_o;
   logic       rx_valid_o;
   logic       rx_ready_i;
   logic       locked_o;
   logic       rx_overrun_o;

   integer     seed = 49;
   int         cyc_cnt = 0;
   int         err_cnt = 0;
   int         n_rx = 0;      // Frames loaded into the hold register
   logic [2:0] phase;         // Link delay in bits
   lane_word_t w1;            // True data word driven 1 edge ago
   lane_word_t w2;            // 2 edges ago
   lane_word_t w3;            // 3 edges ago
   logic       locked_s;      // locked_o seen at the last falling edge
   logic       rst_next;
   logic       ev;            // Expected rx_valid_o
   logic       eo;            // Expected rx_overrun_o
   rx_frame_t  ef;            // Expected held frame

   emmc_serdes_top #(.SETTLE_CYCLES(SETTLE_CYCLES)) uut (.*);

   always #2 txclk_div = ~txclk_div;

   always @(posedge txclk_div) begin
      cyc_cnt <= cyc_cnt + 1;
      if (cyc_cnt > TIMEOUT) begin
         $display("timeout after %0d cycles", cyc_cnt);
         $display("Test failed");
         $fatal(1);
      end
   end

   task automatic check_word(input string name, input lane_word_t got, input lane_word_t exp);
      if (got !== exp) begin
         err_cnt++;
         $display("mismatch %s got %h expected %h", name, got, exp);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   task automatic check_frame(input string name, input rx_frame_t got, input rx_frame_t exp);
      if (got !== exp) begin
         err_cnt++;
         $display("mismatch %s got %h expected %h", name, got, exp);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         err_cnt++;
         $display("mismatch %s got %h expected %h", name, got, exp);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   // One txclk_div cycle: model the edge, drive new inputs, check at the falling edge
   task automatic step(input logic frames_on, input logic bp);
      lane_word_t nw;
      lane_word_t exp_tx;
      lane_word_t exp_clk;
      logic       marked;
      logic       can_load;
      @(posedge txclk_div);
      exp_tx   = '0;  // Idle unless a frame was accepted
      if (tx_valid_i && locked_s) begin
         // Marker in bit 7, dat in 6..3, then dat_oe, cmd_oe and cmd
         exp_tx = {1'b1, tx_frame_i.dat, tx_frame_i.dat_oe, tx_frame_i.cmd_oe, tx_frame_i.cmd};
      end
      exp_clk  = rst ? TRAIN_PATTERN : '0;
      // A driven word reaches the unpacker three edges later
      marked   = locked_s & w3[7];
      can_load = !ev | rx_ready_i;
      if (marked && can_load) begin
         ev     = 1'b1;
         ef.dat = w3[6:3];
         ef.cmd = w3[0];
         n_rx++;
      end else if (rx_ready_i) begin
         ev = 1'b0;
      end
      if (marked && !can_load) eo = 1'b1;  // Dropped word
      nw = '0;  // Idle
      if (frames_on && ($random(seed) & 1)) nw = 8'($random(seed)) | 8'h80;
      rst            <= rst_next;
      tx_valid_i     <= 1'($random(seed));
      tx_frame_i     <= tx_frame_t'(7'($random(seed)));
      rx_ready_i     <= bp ? 1'($random(seed)) : 1'b1;
      // Raw stream is the true stream delayed by phase bits
      rx_data_word_i <= 8'({w1, nw} >> phase);
      rx_clk_word_i  <= 8'({TRAIN_PATTERN, TRAIN_PATTERN} >> phase);
      w3 = w2;
      w2 = w1;
      w1 = nw;
      @(negedge txclk_div);
      check_word("tx_data_word_o", tx_data_word_o, exp_tx);
      check_word("tx_clk_word_o", tx_clk_word_o, exp_clk);
      check_bit("tx_ready_o", tx_ready_o, locked_o);
      check_bit("rx_valid_o", rx_valid_o, ev);
      check_bit("rx_overrun_o", rx_overrun_o, eo);
      if (ev) check_frame("rx_frame_o", rx_frame_o, ef);
      if (!rst) check_bit("locked_o", locked_o, 1'b0);
      locked_s = locked_o;
   endtask

   task automatic wait_lock();
      int n;
      n = 0;
      while (!locked_s && n <= LOCK_BOUND) begin
         step(1'b0, 1'b0);
         n++;
      end
      if (!locked_s) begin
         $display("lock not reached within %0d cycles at phase %0d", LOCK_BOUND, phase);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   initial begin
      rst            = 1'b0;
      rst_next       = 1'b0;
      tx_valid_i     = 1'b0;
      tx_frame_i     = '0;
      rx_ready_i     = 1'b1;
      rx_clk_word_i  = '0;
      rx_data_word_i = '0;
      w1 = '0;
      w2 = '0;
      w3 = '0;
      ev = 1'b0;
      eo = 1'b0;
      ef = '0;
      locked_s = 1'b0;
      phase    = 3'($random(seed));
      repeat (8) step(1'b0, 1'b0);  // Reset held low
      rst_next = 1'b1;
      for (int i = 0; i < N_LOCKS; i++) begin
         if (i > 0) begin
            repeat (6) begin
               step(1'b0, 1'b0);  // Drain with ready high
               check_bit("locked_o", locked_o, 1'b1);
            end
            phase = phase + 3'(1 + (($random(seed) & 32'h7fffffff) % 7));  // Always a new phase
            repeat (6) begin
               if (locked_s) step(1'b0, 1'b0);
            end
            if (locked_s) begin
               $display("lock did not drop after phase change to %0d", phase);
               $display("Test failed");
               $fatal(1);
            end
         end
         wait_lock();
         repeat (FRAME_CYC) begin
            step(1'b1, i != 0);  // First lock runs without back-pressure
            check_bit("locked_o", locked_o, 1'b1);  // Phase is fixed, lock holds
         end
      end
      repeat (6) step(1'b0, 1'b0);
      if (n_rx == 0 || !eo) begin
         $display("stimulus produced no received frames or no overrun");
         err_cnt++;
      end
      if (err_cnt == 0) begin
         $display("Test passed");
         $finish;
      end else begin
         $display("Test failed");
         $fatal(1);
      end
   end

endmodule

// ==== src.f ====
emmc_serdes_pkg.sv
emmc_tx_framer.sv
emmc_lane_deser.sv
emmc_bitslip_ctrl.sv
emmc_rx_unpack.sv
emmc_serdes_top.sv
emmc_serdes_properties.sv
tb_emmc_serdes.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_emmc_serdes
BUILD_DIR ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "Variables: VERILATOR TOP BUILD_DIR FILELIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
